//--- common/fwd_defines.svh
`ifndef FWD_DEFINES_SVH
`define FWD_DEFINES_SVH

// Datapath widths
`define XLEN        64
`define REG_IDX_W   5
`define INSTR_W     32
`define OPCODE_W    7

// RV64I major opcodes
`define OPC_BRANCH  7'b1100011  // BEQ, BNE, BLT, BGE, BLTU, BGEU
`define OPC_LOAD    7'b0000011  // LB through LD

`endif

//--- common/fwd_pkg.sv
`include "fwd_defines.svh"

package fwd_pkg;

    // Decode, execute and memory/writeback
    localparam int STAGES = 3;

    // Operand source picked for the instruction in decode
    typedef enum logic [1:0] {
        FWD_RF       = 2'd0,  // Register file value from decode
        FWD_MEM_LOAD = 2'd1,  // Load data returned in memory stage
        FWD_EX_ALU   = 2'd2,  // ALU result of execute stage
        FWD_MEM_ALU  = 2'd3   // ALU result carried into memory stage
    } fwd_src_t;

    // Register identifiers of one instruction in flight
    typedef struct packed {
        logic [`REG_IDX_W-1:0] dest;
        logic [`REG_IDX_W-1:0] src1;
        logic [`REG_IDX_W-1:0] src2;
    } stage_regs_t;

endpackage

//--- common/stage_info_if.sv
`timescale 1ns/1ns

// Register and load state of the tracked stages, index 0 is decode
interface stage_info_if;
    import fwd_pkg::*;

    stage_regs_t [STAGES-1:0] regs;
    logic [STAGES-1:0] is_load;  // Instruction in that stage reads data memory
    logic bubble;                // Zero the execute entry at the next edge

    modport tracker (
        output regs,
        output is_load,
        input  bubble
    );

    modport detector (
        input  regs,
        input  is_load,
        output bubble
    );

endinterface

//--- logic/stage_tracker.sv
`timescale 1ns/1ns
`include "fwd_defines.svh"

module stage_tracker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`REG_IDX_W-1:0] dest,
    input  logic [`REG_IDX_W-1:0] src1,
    input  logic [`REG_IDX_W-1:0] src2,
    input  logic                  is_load,
    stage_info_if.tracker         info
);
    import fwd_pkg::*;

    stage_regs_t [STAGES-1:0] regs_q;
    logic [STAGES-1:0] load_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            regs_q <= '0;
            load_q <= '0;
        end else begin
            // Decode entry follows the decoder every cycle
            regs_q[0].dest <= dest;
            regs_q[0].src1 <= src1;
            regs_q[0].src2 <= src2;
            load_q[0]      <= is_load;

            // A bubble enters execute in place of the stalled instruction
            if (info.bubble) begin
                regs_q[1] <= '0;
                load_q[1] <= 1'b0;
            end else begin
                regs_q[1] <= regs_q[0];
                load_q[1] <= load_q[0];
            end

            regs_q[2] <= regs_q[1];  // Execute moves on to memory
            load_q[2] <= load_q[1];
        end
    end

    assign info.regs    = regs_q;
    assign info.is_load = load_q;

    // Bubbles are only requested behind a load in execute
    a_bubble_behind_load: assert property (
        @(posedge clk) disable iff (rst)
        info.bubble |-> (info.is_load[1] && info.regs[1].dest != '0)
    );

    // The zeroed entry never looks like a load, so no second bubble follows
    a_single_bubble: assert property (
        @(posedge clk) disable iff (rst)
        info.bubble |=> !info.bubble
    );

endmodule

//--- logic/hazard_detect.sv
`timescale 1ns/1ns
`include "fwd_defines.svh"

module hazard_detect (
    input  logic             clk,
    input  logic             rst,
    stage_info_if.detector   info,
    output fwd_pkg::fwd_src_t fwd_sel_a,
    output fwd_pkg::fwd_src_t fwd_sel_b,
    output logic             f_to_d_enable,
    output logic             d_to_e_enable
);
    import fwd_pkg::*;

    logic [`REG_IDX_W-1:0] src1;
    logic [`REG_IDX_W-1:0] src2;
    logic ex_hit_a;   // Operand A written by the execute instruction
    logic ex_hit_b;
    logic mem_hit_a;  // Operand A written by the memory instruction
    logic mem_hit_b;
    logic stall;

    // Nearer writer wins, a load in execute cannot forward yet
    function automatic fwd_src_t pick_src(
        input logic             ex_hit,
        input logic             mem_hit,
        input logic [STAGES-1:0] load
    );
        fwd_src_t sel;
        sel = FWD_RF;
        if (ex_hit) begin
            sel = load[1] ? FWD_RF : FWD_EX_ALU;  // Load case is resolved by the stall
        end else if (mem_hit) begin
            sel = load[2] ? FWD_MEM_LOAD : FWD_MEM_ALU;
        end
        return sel;
    endfunction

    assign src1 = info.regs[0].src1;
    assign src2 = info.regs[0].src2;

    // x0 is hardwired to zero and is never forwarded
    assign ex_hit_a  = (src1 != '0) && (info.regs[1].dest == src1);
    assign ex_hit_b  = (src2 != '0) && (info.regs[1].dest == src2);
    assign mem_hit_a = (src1 != '0) && (info.regs[2].dest == src1);
    assign mem_hit_b = (src2 != '0) && (info.regs[2].dest == src2);

    // Load-use pair, load data is one stage too late
    assign stall = info.is_load[1] && (ex_hit_a || ex_hit_b);

    assign info.bubble = stall;

    always_comb begin
        fwd_sel_a = pick_src(ex_hit_a, mem_hit_a, info.is_load);
        fwd_sel_b = pick_src(ex_hit_b, mem_hit_b, info.is_load);
    end

    // Hold fetch and decode for the one cycle after the hazard
    always_ff @(posedge clk) begin
        if (rst) begin
            f_to_d_enable <= 1'b1;
            d_to_e_enable <= 1'b1;
        end else begin
            f_to_d_enable <= !stall;
            d_to_e_enable <= !stall;
        end
    end

    // The bubble in execute keeps the stall from re-arming
    a_single_cycle_stall: assert property (
        @(posedge clk) disable iff (rst)
        (!f_to_d_enable || !d_to_e_enable) |=> (f_to_d_enable && d_to_e_enable)
    );

    // Stalled load sits in memory stage once the bubble is in place
    a_load_moves_to_mem: assert property (
        @(posedge clk) disable iff (rst)
        stall |=> (info.is_load[2] && info.regs[2].dest != '0)
    );

endmodule

//--- forwarding/operand_a_route.sv
`timescale 1ns/1ns
`include "fwd_defines.svh"

module operand_a_route (
    input  fwd_pkg::fwd_src_t      sel,
    input  logic [`OPCODE_W-1:0]   opcode,
    input  logic [`XLEN-1:0]       dec_alu_a,
    input  logic [`XLEN-1:0]       dec_jbl_data1,
    input  logic [`XLEN-1:0]       dec_jbl_addr,
    input  logic [`XLEN-1:0]       alu_result,
    input  logic [`XLEN-1:0]       mem_load_data,
    input  logic [`XLEN-1:0]       mem_alu_data,
    output logic [`XLEN-1:0]       alu_a,
    output logic [`XLEN-1:0]       jbl_data1,
    output logic [`XLEN-1:0]       jbl_addr
);
    import fwd_pkg::*;

    logic [`XLEN-1:0] fwd_val;
    logic is_branch;
    logic forwarded;

    assign is_branch = (opcode == `OPC_BRANCH);
    assign forwarded = (sel != FWD_RF);

    always_comb begin
        case (sel)
            FWD_MEM_LOAD: fwd_val = mem_load_data;
            FWD_EX_ALU:   fwd_val = alu_result;
            FWD_MEM_ALU:  fwd_val = mem_alu_data;
            default:      fwd_val = dec_alu_a;  // Register file operand
        endcase
    end

    always_comb begin
        alu_a     = fwd_val;
        jbl_data1 = dec_jbl_data1;
        jbl_addr  = dec_jbl_addr;
        if (forwarded) begin
            // rs1 is a comparand for branches, a base address for JALR
            if (is_branch) begin
                jbl_data1 = fwd_val;
            end else begin
                jbl_addr = fwd_val;
            end
        end
    end

endmodule

//--- forwarding/operand_b_route.sv
`timescale 1ns/1ns
`include "fwd_defines.svh"

module operand_b_route (
    input  fwd_pkg::fwd_src_t  sel,
    input  logic               is_store,
    input  logic [`XLEN-1:0]   dec_alu_b,
    input  logic [`XLEN-1:0]   dec_jbl_data2,
    input  logic [`XLEN-1:0]   dec_store_data,
    input  logic [`XLEN-1:0]   alu_result,
    input  logic [`XLEN-1:0]   mem_load_data,
    input  logic [`XLEN-1:0]   mem_alu_data,
    output logic [`XLEN-1:0]   alu_b,
    output logic [`XLEN-1:0]   jbl_data2,
    output logic [`XLEN-1:0]   store_data
);
    import fwd_pkg::*;

    always_comb begin
        alu_b      = dec_alu_b;
        jbl_data2  = dec_jbl_data2;
        store_data = dec_store_data;

        case (sel)
            FWD_MEM_LOAD: begin
                // Loaded value replaces every use of rs2
                alu_b      = mem_load_data;
                jbl_data2  = mem_load_data;
                store_data = mem_load_data;
            end
            FWD_EX_ALU: begin
                jbl_data2 = alu_result;
                if (is_store) begin
                    store_data = alu_result;  // ALU B keeps the offset
                end else begin
                    alu_b = alu_result;
                end
            end
            FWD_MEM_ALU: begin
                jbl_data2 = mem_alu_data;
                if (is_store) begin
                    store_data = mem_alu_data;
                end else begin
                    alu_b = mem_alu_data;
                end
            end
            default: begin
                // Decode values already in place
            end
        endcase
    end

endmodule

//--- logic/pipeline_control.sv
`timescale 1ns/1ns
`include "fwd_defines.svh"

module pipeline_control (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`INSTR_W-1:0]   instruction,      // Instruction in decode
    input  logic [`REG_IDX_W-1:0] destination_reg,
    input  logic [`REG_IDX_W-1:0] source_reg1,
    input  logic [`REG_IDX_W-1:0] source_reg2,
    input  logic                  dm_read_enable,   // Decode instruction is a load
    input  logic                  dm_write_enable,  // Decode instruction is a store
    input  logic [`XLEN-1:0]      dm_read_data,
    input  logic [`XLEN-1:0]      alu_data_out,
    input  logic [`XLEN-1:0]      dm_data_bypass,
    input  logic [`XLEN-1:0]      dec_alu_data_in_a,
    input  logic [`XLEN-1:0]      dec_alu_data_in_b,
    input  logic [`XLEN-1:0]      dec_jbl_data_in1,
    input  logic [`XLEN-1:0]      dec_jbl_data_in2,
    input  logic [`XLEN-1:0]      dec_jbl_address_in,
    input  logic [`XLEN-1:0]      dec_dm_write_data,
    output logic [`XLEN-1:0]      alu_data_in_a,
    output logic [`XLEN-1:0]      alu_data_in_b,
    output logic [`XLEN-1:0]      jbl_data_in1,
    output logic [`XLEN-1:0]      jbl_data_in2,
    output logic [`XLEN-1:0]      jbl_address_in,
    output logic [`XLEN-1:0]      dm_write_data,
    output logic                  f_to_d_enable,
    output logic                  d_to_e_enable
);
    import fwd_pkg::*;

    fwd_src_t fwd_sel_a;
    fwd_src_t fwd_sel_b;

    stage_info_if info_if ();

    stage_tracker stage_tracker_inst (
        .clk     (clk),
        .rst     (rst),
        .dest    (destination_reg),
        .src1    (source_reg1),
        .src2    (source_reg2),
        .is_load (dm_read_enable),
        .info    (info_if.tracker)
    );

    hazard_detect hazard_detect_inst (
        .clk           (clk),
        .rst           (rst),
        .info          (info_if.detector),
        .fwd_sel_a     (fwd_sel_a),
        .fwd_sel_b     (fwd_sel_b),
        .f_to_d_enable (f_to_d_enable),
        .d_to_e_enable (d_to_e_enable)
    );

    operand_a_route operand_a_route_inst (
        .sel           (fwd_sel_a),
        .opcode        (instruction[`OPCODE_W-1:0]),
        .dec_alu_a     (dec_alu_data_in_a),
        .dec_jbl_data1 (dec_jbl_data_in1),
        .dec_jbl_addr  (dec_jbl_address_in),
        .alu_result    (alu_data_out),
        .mem_load_data (dm_read_data),
        .mem_alu_data  (dm_data_bypass),
        .alu_a         (alu_data_in_a),
        .jbl_data1     (jbl_data_in1),
        .jbl_addr      (jbl_address_in)
    );

    operand_b_route operand_b_route_inst (
        .sel            (fwd_sel_b),
        .is_store       (dm_write_enable),
        .dec_alu_b      (dec_alu_data_in_b),
        .dec_jbl_data2  (dec_jbl_data_in2),
        .dec_store_data (dec_dm_write_data),
        .alu_result     (alu_data_out),
        .mem_load_data  (dm_read_data),
        .mem_alu_data   (dm_data_bypass),
        .alu_b          (alu_data_in_b),
        .jbl_data2      (jbl_data_in2),
        .store_data     (dm_write_data)
    );

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ns

// Free-running clock for the testbench
module tb_clock #(
    parameter int PERIOD = 100  // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

//--- testbench/fwd_checker.sv
`timescale 1ns/1ns
`include "fwd_defines.svh"

module fwd_checker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       check_en,
    input  logic                       done,
    input  logic [7:0]                 test_id,
    input  fwd_pkg::fwd_src_t          exp_sel_a,  // Hand-written in the stimulus table
    input  fwd_pkg::fwd_src_t          exp_sel_b,
    input  logic                       exp_en,
    input  logic [`REG_IDX_W-1:0]      dest,
    input  logic [`REG_IDX_W-1:0]      src1,
    input  logic [`REG_IDX_W-1:0]      src2,
    input  logic                       is_load,
    input  logic                       is_store,
    input  logic [`OPCODE_W-1:0]       opcode,
    input  logic [8:0][`XLEN-1:0]      din,   // read, alu, bypass, a, b, j1, j2, jaddr, wdata
    input  logic [5:0][`XLEN-1:0]      dout,  // alu a, alu b, j1, j2, jaddr, wdata
    input  logic                       f_to_d_enable,
    input  logic                       d_to_e_enable,
    output int                         pass_count,
    output int                         fail_count,
    output logic                       report_done
);
    import fwd_pkg::*;

    stage_regs_t m_regs [0:STAGES-1];  // Reference copy of decode, execute, memory
    logic [STAGES-1:0] m_load;
    logic en_q;                        // Expected level of both enables
    int errs;
    int checks;
    logic [7:0] cur_id;
    logic started;

    // Dependent instruction right behind a load in execute
    function automatic logic load_use();
        return m_load[1] && (m_regs[1].dest != '0) &&
               ((m_regs[1].dest == m_regs[0].src1) || (m_regs[1].dest == m_regs[0].src2));
    endfunction

    function automatic fwd_src_t source_of(input logic [`REG_IDX_W-1:0] src);
        if (src == '0) return FWD_RF;
        if (m_regs[1].dest == src) return m_load[1] ? FWD_RF : FWD_EX_ALU;
        if (m_regs[2].dest == src) return m_load[2] ? FWD_MEM_LOAD : FWD_MEM_ALU;
        return FWD_RF;
    endfunction

    function automatic logic [`XLEN-1:0] value_of(input fwd_src_t sel, input logic [`XLEN-1:0] dec);
        case (sel)
            FWD_MEM_LOAD: return din[0];
            FWD_EX_ALU:   return din[1];
            FWD_MEM_ALU:  return din[2];
            default:      return dec;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [`XLEN-1:0] got,
                               input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errs++;
        end
    endtask

    task automatic compare_outputs();
        fwd_src_t sel_a;
        fwd_src_t sel_b;
        logic [`XLEN-1:0] fa;
        logic [`XLEN-1:0] fb;
        logic br;
        logic b_to_alu;
        logic b_to_store;
        sel_a = source_of(m_regs[0].src1);
        sel_b = source_of(m_regs[0].src2);
        fa = value_of(sel_a, din[3]);
        fb = value_of(sel_b, din[4]);
        br = (opcode == `OPC_BRANCH);
        b_to_alu = (sel_b == FWD_MEM_LOAD) || (sel_b != FWD_RF && !is_store);
        b_to_store = (sel_b == FWD_MEM_LOAD) || (sel_b != FWD_RF && is_store);
        if (sel_a != exp_sel_a || sel_b != exp_sel_b || en_q != exp_en) begin
            $display("Test %0d: stimulus table disagrees with the forwarding rules at %0t",
                     test_id, $time);
            errs++;
        end
        check_value("alu_data_in_a", dout[0], fa);
        check_value("alu_data_in_b", dout[1], b_to_alu ? fb : din[4]);
        check_value("jbl_data_in1", dout[2], (sel_a != FWD_RF && br) ? fa : din[5]);
        check_value("jbl_data_in2", dout[3], (sel_b != FWD_RF) ? fb : din[6]);
        check_value("jbl_address_in", dout[4], (sel_a != FWD_RF && !br) ? fa : din[7]);
        check_value("dm_write_data", dout[5], b_to_store ? fb : din[8]);
        check_value("f_to_d_enable", f_to_d_enable, en_q);
        check_value("d_to_e_enable", d_to_e_enable, en_q);
        checks++;
    endtask

    task automatic close_test();
        if (errs == 0) begin
            pass_count++;
            $display("Test %0d: passed, %0d cycles checked", cur_id, checks);
        end else begin
            fail_count++;
            $display("Test %0d: failed with %0d mismatches", cur_id, errs);
        end
        errs = 0;
        checks = 0;
    endtask

    initial begin
        pass_count = 0;
        fail_count = 0;
        report_done = 1'b0;
        errs = 0;
        checks = 0;
        started = 1'b0;
        cur_id = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                m_regs[i] <= '0;
            end
            m_load <= '0;
            en_q   <= 1'b1;
        end else begin
            m_regs[0] <= {dest, src1, src2};
            m_load[0] <= is_load;
            m_regs[1] <= load_use() ? '0 : m_regs[0];  // Bubble on load-use
            m_load[1] <= load_use() ? 1'b0 : m_load[0];
            m_regs[2] <= m_regs[1];
            m_load[2] <= m_load[1];
            en_q      <= !load_use();
        end
    end

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (check_en && !rst) begin
            if (started && test_id != cur_id) close_test();
            started = 1'b1;
            cur_id  = test_id;
            compare_outputs();
        end
        if (done && !report_done) begin
            if (started) close_test();
            report_done = 1'b1;
        end
    end

endmodule

//--- testbench/pipeline_control_tb.sv
`timescale 1ns/1ns
`include "fwd_defines.svh"

module pipeline_control_tb;
    import fwd_pkg::*;

    typedef struct packed {
        logic [7:0]            id;
        logic [`REG_IDX_W-1:0] dest;
        logic [`REG_IDX_W-1:0] src1;
        logic [`REG_IDX_W-1:0] src2;
        logic                  ld;
        logic                  st;
        logic [`OPCODE_W-1:0]  opc;
        fwd_src_t              exp_a;
        fwd_src_t              exp_b;
        logic                  exp_en;
        logic [8:0][`XLEN-1:0] data;  // Same order as data_bus
    } row_t;

    localparam int MAX_ROWS = 32;
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;

    row_t rows [0:MAX_ROWS-1];
    int n_rows;
    integer seed;
    int waited;
    logic hang;

    logic clk;
    logic rst;
    logic [`INSTR_W-1:0] instruction;
    logic [`REG_IDX_W-1:0] destination_reg;
    logic [`REG_IDX_W-1:0] source_reg1;
    logic [`REG_IDX_W-1:0] source_reg2;
    logic dm_read_enable;
    logic dm_write_enable;
    logic [8:0][`XLEN-1:0] data_bus;  // read, alu, bypass, a, b, j1, j2, jaddr, wdata
    wire [5:0][`XLEN-1:0] out_bus;
    wire f_to_d_enable;
    wire d_to_e_enable;

    logic check_en;
    logic done;
    logic [7:0] test_id;
    fwd_src_t exp_a;
    fwd_src_t exp_b;
    logic exp_en;
    int pass_count;
    int fail_count;
    logic report_done;

    tb_clock #(.PERIOD(100)) clock_inst (.clk(clk));

    pipeline_control pipeline_control_inst (
        .clk                (clk),
        .rst                (rst),
        .instruction        (instruction),
        .destination_reg    (destination_reg),
        .source_reg1        (source_reg1),
        .source_reg2        (source_reg2),
        .dm_read_enable     (dm_read_enable),
        .dm_write_enable    (dm_write_enable),
        .dm_read_data       (data_bus[0]),
        .alu_data_out       (data_bus[1]),
        .dm_data_bypass     (data_bus[2]),
        .dec_alu_data_in_a  (data_bus[3]),
        .dec_alu_data_in_b  (data_bus[4]),
        .dec_jbl_data_in1   (data_bus[5]),
        .dec_jbl_data_in2   (data_bus[6]),
        .dec_jbl_address_in (data_bus[7]),
        .dec_dm_write_data  (data_bus[8]),
        .alu_data_in_a      (out_bus[0]),
        .alu_data_in_b      (out_bus[1]),
        .jbl_data_in1       (out_bus[2]),
        .jbl_data_in2       (out_bus[3]),
        .jbl_address_in     (out_bus[4]),
        .dm_write_data      (out_bus[5]),
        .f_to_d_enable      (f_to_d_enable),
        .d_to_e_enable      (d_to_e_enable)
    );

    fwd_checker fwd_checker_inst (
        .clk           (clk),
        .rst           (rst),
        .check_en      (check_en),
        .done          (done),
        .test_id       (test_id),
        .exp_sel_a     (exp_a),
        .exp_sel_b     (exp_b),
        .exp_en        (exp_en),
        .dest          (destination_reg),
        .src1          (source_reg1),
        .src2          (source_reg2),
        .is_load       (dm_read_enable),
        .is_store      (dm_write_enable),
        .opcode        (instruction[`OPCODE_W-1:0]),
        .din           (data_bus),
        .dout          (out_bus),
        .f_to_d_enable (f_to_d_enable),
        .d_to_e_enable (d_to_e_enable),
        .pass_count    (pass_count),
        .fail_count    (fail_count),
        .report_done   (report_done)
    );

    task automatic add_row(input logic [7:0] id, input logic [`REG_IDX_W-1:0] dest,
                           input logic [`REG_IDX_W-1:0] s1, input logic [`REG_IDX_W-1:0] s2,
                           input logic ld, input logic st, input logic [6:0] opc,
                           input fwd_src_t ea, input fwd_src_t eb, input logic en);
        row_t r;
        r.id = id;
        r.dest = dest;
        r.src1 = s1;
        r.src2 = s2;
        r.ld = ld;
        r.st = st;
        r.opc = opc;
        r.exp_a = ea;
        r.exp_b = eb;
        r.exp_en = en;
        for (int k = 0; k < 9; k++) begin
            r.data[k] = {$random(seed), $random(seed)};
        end
        rows[n_rows] = r;
        n_rows++;
    endtask

    // Register fields lead by one cycle since the tracker captures them
    task automatic present_regs(input row_t r);
        destination_reg = r.dest;
        source_reg1     = r.src1;
        source_reg2     = r.src2;
        dm_read_enable  = r.ld;
    endtask

    task automatic drive_row(input int idx);
        row_t cur;
        cur = rows[idx];
        present_regs((idx + 1 < n_rows) ? rows[idx + 1] : row_t'('0));
        instruction     = {{(`INSTR_W - `OPCODE_W){1'b0}}, cur.opc};
        dm_write_enable = cur.st;
        data_bus        = cur.data;
        test_id         = cur.id;
        exp_a           = cur.exp_a;
        exp_b           = cur.exp_b;
        exp_en          = cur.exp_en;
        check_en        = 1'b1;
    endtask

    initial begin
        seed = 32'h45382b13;
        n_rows = 0;
        hang = 1'b0;
        rst = 1'b1;
        instruction = '0;
        destination_reg = '0;
        source_reg1 = '0;
        source_reg2 = '0;
        dm_read_enable = 1'b0;
        dm_write_enable = 1'b0;
        data_bus = '0;
        check_en = 1'b0;
        done = 1'b0;
        test_id = '0;
        exp_a = FWD_RF;
        exp_b = FWD_RF;
        exp_en = 1'b1;

        // id, rd, rs1, rs2, load, store, opcode, source A, source B, enables
        add_row(1, 0, 0, 0, 0, 0, OPC_OP, FWD_RF, FWD_RF, 1);   // Idle after reset
        add_row(1, 5, 1, 2, 0, 0, OPC_OP, FWD_RF, FWD_RF, 1);
        add_row(2, 6, 5, 3, 0, 0, OPC_OP, FWD_EX_ALU, FWD_RF, 1);
        add_row(2, 6, 6, 5, 0, 0, OPC_OP, FWD_EX_ALU, FWD_MEM_ALU, 1);
        add_row(2, 6, 1, 2, 0, 0, OPC_OP, FWD_RF, FWD_RF, 1);
        add_row(2, 8, 6, 6, 0, 0, OPC_OP, FWD_EX_ALU, FWD_EX_ALU, 1);  // Nearer x6 wins
        add_row(3, 9, 0, 0, 0, 0, OPC_OP, FWD_RF, FWD_RF, 1);
        add_row(3, 10, 1, 2, 0, 0, OPC_OP, FWD_RF, FWD_RF, 1);
        add_row(3, 11, 9, 3, 0, 0, OPC_OP, FWD_MEM_ALU, FWD_RF, 1);
        add_row(3, 12, 1, 0, 1, 0, `OPC_LOAD, FWD_RF, FWD_RF, 1);
        add_row(3, 13, 2, 3, 0, 0, OPC_OP, FWD_RF, FWD_RF, 1);
        add_row(3, 14, 3, 12, 0, 0, OPC_OP, FWD_RF, FWD_MEM_LOAD, 1);
        add_row(4, 15, 1, 2, 0, 0, OPC_OP, FWD_RF, FWD_RF, 1);
        add_row(4, 0, 15, 14, 0, 0, `OPC_BRANCH, FWD_EX_ALU, FWD_MEM_ALU, 1);
        add_row(4, 16, 1, 2, 0, 0, OPC_OP, FWD_RF, FWD_RF, 1);
        add_row(4, 0, 15, 16, 0, 1, OPC_STORE, FWD_RF, FWD_EX_ALU, 1);
        add_row(4, 0, 16, 0, 0, 0, OPC_JALR, FWD_MEM_ALU, FWD_RF, 1);
        add_row(4, 0, 1, 2, 0, 0, OPC_OP, FWD_RF, FWD_RF, 1);   // Writes x0
        add_row(4, 17, 0, 0, 0, 0, OPC_OP, FWD_RF, FWD_RF, 1);  // Reads x0
        add_row(5, 18, 1, 0, 1, 0, `OPC_LOAD, FWD_RF, FWD_RF, 1);
        add_row(5, 19, 18, 2, 0, 0, OPC_OP, FWD_RF, FWD_RF, 1);
        add_row(5, 19, 18, 2, 0, 0, OPC_OP, FWD_MEM_LOAD, FWD_RF, 0);  // Held by stall
        add_row(5, 0, 0, 0, 0, 0, OPC_OP, FWD_RF, FWD_RF, 1);

        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;
        present_regs(rows[0]);

        for (int r = 0; r < n_rows; r++) begin
            @(posedge clk);
            #10;
            drive_row(r);
        end
        @(posedge clk);
        #10;
        check_en = 1'b0;

        waited = 0;
        while (!(f_to_d_enable && d_to_e_enable) && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (!(f_to_d_enable && d_to_e_enable)) begin
            $display("Stall never ended, enables still low after 10 cycles");
            hang = 1'b1;
        end

        done = 1'b1;
        waited = 0;
        while (!report_done && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (!report_done) begin
            $display("Checker did not close its report within 10 cycles");
            hang = 1'b1;
        end

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0 && !hang) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+common
common/fwd_pkg.sv
common/stage_info_if.sv
logic/stage_tracker.sv
logic/hazard_detect.sv
forwarding/operand_a_route.sv
forwarding/operand_b_route.sv
logic/pipeline_control.sv
testbench/tb_clock.sv
testbench/fwd_checker.sv
testbench/pipeline_control_tb.sv
